// File: build.f
+incdir+source
source/cls_pkg.sv
source/cls_boot_timer.sv
source/cls_sequence_loader.sv
source/cls_fifo_feeder.sv
source/cls_driver_fsm.sv
source/pmod_cls_driver.sv
testbench/tb_pmod_cls_driver.sv

// File: testbench/tb_pmod_cls_driver.sv
// testbench with SPI master model, LFSR, stimulus table, value check, timeout and report
`timescale 1ns/1ps
`include "cls_config.svh"

module tb_pmod_cls_driver
    import cls_pkg::*;
();

    localparam int lp_boot_ticks = 20;
    localparam int lp_rows = 5;
    // a byte may wait several ticks for tx_ready, and each burst ends with an idle wait
    localparam int lp_burst_ticks = `CLS_BURST_MAX_BYTES * 8 + 8 + 2;
    localparam int lp_row_ticks = 2 * lp_burst_ticks + 4;
    localparam int lp_limit_cycles = 4 * (lp_boot_ticks + 4 + lp_rows * lp_row_ticks);

    // one row of the stimulus table, expected bytes are left-aligned
    typedef struct packed {
        cls_cmd_t       cmd;
        cls_line_t      line1;
        cls_line_t      line2;
        logic           alter;
        int             n_bytes;
        logic [183:0]   bytes;
        int             n_bursts;
        int             len0;
        int             len1;
    } row_t;

    logic          i_ext_spi_clk_x = 1'b0;
    logic          i_srst;
    logic          i_spi_ce_4x;
    logic          o_command_ready;
    cls_cmd_t      i_cmd;
    cls_line_t     i_text_line1;
    cls_line_t     i_text_line2;
    cls_spi_req_t  o_spi_req;
    cls_spi_stat_t i_spi_stat;

    row_t        table_rows [lp_rows];
    logic [31:0] lfsr = 32'h4dd83594;
    logic [1:0]  ce_div = 2'd0;
    int          busy_ticks = 0;
    int          cycle_cnt = 0;
    int          err_cnt = 0;
    int          fail_tests = 0;
    cls_byte_t   got_bytes[$];
    int          got_lens[$];
    int          got_go_pos[$];

    pmod_cls_driver #(
        .P_BOOT_TICKS (lp_boot_ticks)
    ) dut0 (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .o_command_ready (o_command_ready),
        .i_cmd           (i_cmd),
        .i_text_line1    (i_text_line1),
        .i_text_line2    (i_text_line2),
        .o_spi_req       (o_spi_req),
        .i_spi_stat      (i_spi_stat)
    );

    initial begin
        forever #20 i_ext_spi_clk_x = ~i_ext_spi_clk_x;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // the LFSR steps once for every bit drawn
    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic set_row(input int r, input cls_cmd_t cmd, input cls_line_t l1,
                           input cls_line_t l2, input logic alter, input int n_bytes,
                           input logic [183:0] bytes, input int n_bursts,
                           input int len0, input int len1);
        row_t row;
        row.cmd = cmd;
        row.line1 = l1;
        row.line2 = l2;
        row.alter = alter;
        row.n_bytes = n_bytes;
        row.bytes = bytes;
        row.n_bursts = n_bursts;
        row.len0 = len0;
        row.len1 = len1;
        table_rows[r] = row;
    endtask

    // ------------------------------------------------------------------------
    // SPI master model
    // ------------------------------------------------------------------------

    // clock enable every fourth cycle, tx_ready is random back-pressure
    always @(negedge i_ext_spi_clk_x) begin
        int bit_v;
        ce_div = ce_div + 2'd1;
        i_spi_ce_4x = (ce_div == 2'd3);
        take_bits(1, bit_v);
        i_spi_stat.tx_ready = bit_v[0];
        i_spi_stat.spi_idle = (busy_ticks == 0);
    end

    // records the FIFO traffic, a go keeps the master busy for 1 to 8 ticks
    always @(posedge i_ext_spi_clk_x) begin
        int wait_v;
        if (!i_srst && i_spi_ce_4x) begin
            if (o_spi_req.tx_enqueue) begin
                if (!i_spi_stat.tx_ready) begin
                    $display("a byte was enqueued while tx_ready was low");
                    err_cnt++;
                end
                got_bytes.push_back(o_spi_req.tx_data);
            end
            if (o_spi_req.go_stand) begin
                got_lens.push_back(int'(o_spi_req.tx_len));
                got_go_pos.push_back(got_bytes.size());
                take_bits(3, wait_v);
                busy_ticks = wait_v + 1;
            end else if (busy_ticks != 0) begin
                busy_ticks = busy_ticks - 1;
            end
        end
    end

    always @(posedge i_ext_spi_clk_x) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == lp_limit_cycles) begin
            $display("timeout: the run did not end within %0d clock cycles", lp_limit_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    task automatic run_row(input int r);
        row_t row;
        int   base_err;
        logic accepted;
        row = table_rows[r];
        base_err = err_cnt;
        accepted = 1'b0;
        @(negedge i_ext_spi_clk_x);
        got_bytes.delete();
        got_lens.delete();
        got_go_pos.delete();
        i_cmd = row.cmd;
        i_text_line1 = row.line1;
        i_text_line2 = row.line2;
        while (!accepted) begin
            @(posedge i_ext_spi_clk_x);
            accepted = i_spi_ce_4x && o_command_ready;
        end
        @(negedge i_ext_spi_clk_x);
        i_cmd = '0;
        // new text after acceptance must not reach the display
        if (row.alter) begin
            i_text_line1 = ~row.line1;
            i_text_line2 = ~row.line2;
        end
        compare_value("o_command_ready", o_command_ready, 0);
        while (!o_command_ready) begin
            @(posedge i_ext_spi_clk_x);
        end
        // ready may only come back once every burst has gone and the master is idle
        compare_value("go_stand count", got_lens.size(), row.n_bursts);
        compare_value("spi_idle", busy_ticks == 0, 1);
        compare_value("tx_enqueue count", got_bytes.size(), row.n_bytes);
        for (int k = 0; k < row.n_bytes && k < got_bytes.size(); k++) begin
            compare_value($sformatf("tx_data[%0d]", k), got_bytes[k],
                          row.bytes[183 - 8 * k -: 8]);
        end
        if (got_lens.size() > 0) begin
            compare_value("tx_len[0]", got_lens[0], row.len0);
            compare_value("go byte index[0]", got_go_pos[0], row.len0);
        end
        if (got_lens.size() > 1) begin
            compare_value("tx_len[1]", got_lens[1], row.len1);
            compare_value("go byte index[1]", got_go_pos[1], row.len0 + row.len1);
        end
        if (err_cnt != base_err) begin
            fail_tests++;
        end
        $display("test %0d (cmd %b): %s", r + 1, row.cmd,
                 (err_cnt == base_err) ? "passed" : "failed");
    endtask

    initial begin
        int ticks;
        i_srst = 1'b1;
        i_spi_ce_4x = 1'b0;
        i_cmd = '0;
        i_text_line1 = '0;
        i_text_line2 = '0;
        i_spi_stat.tx_ready = 1'b0;
        i_spi_stat.spi_idle = 1'b1;
        ticks = 0;
        set_row(0, 3'b100, "HELLO WORLD 1234", "PMOD CLS LINE 2!", 1'b0, 4,
                {8'h1B, 8'h5B, 8'h30, 8'h6A, 152'h0}, 1, 4, 0);
        set_row(1, 3'b010, "HELLO WORLD 1234", "PMOD CLS LINE 2!", 1'b0, 23,
                {8'h1B, 8'h5B, 8'h30, 8'h3B, 8'h30, 8'h30, 8'h48, "HELLO WORLD 1234"},
                2, 7, 16);
        set_row(2, 3'b001, "HELLO WORLD 1234", "PMOD CLS LINE 2!", 1'b1, 23,
                {8'h1B, 8'h5B, 8'h31, 8'h3B, 8'h30, 8'h30, 8'h48, "PMOD CLS LINE 2!"},
                2, 7, 16);
        set_row(3, 3'b111, "0123456789ABCDEF", "fedcba9876543210", 1'b0, 4,
                {8'h1B, 8'h5B, 8'h30, 8'h6A, 152'h0}, 1, 4, 0);
        set_row(4, 3'b011, "0123456789ABCDEF", "fedcba9876543210", 1'b1, 23,
                {8'h1B, 8'h5B, 8'h30, 8'h3B, 8'h30, 8'h30, 8'h48, "0123456789ABCDEF"},
                2, 7, 16);
        repeat (2) @(negedge i_ext_spi_clk_x);
        i_srst = 1'b0;
        // boot wait, the FSM reaches idle one tick after the timer expires
        while (!o_command_ready) begin
            @(posedge i_ext_spi_clk_x);
            compare_value("tx_enqueue", o_spi_req.tx_enqueue, 0);
            compare_value("go_stand", o_spi_req.go_stand, 0);
            if (!o_command_ready && i_spi_ce_4x) begin
                ticks++;
            end
        end
        compare_value("boot ticks", ticks, lp_boot_ticks + 1);
        if (err_cnt != 0) begin
            fail_tests++;
        end
        $display("test 0 (boot wait): %s", (err_cnt == 0) ? "passed" : "failed");
        for (int r = 0; r < lp_rows; r++) begin
            run_row(r);
        end
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 lp_rows + 1, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_pmod_cls_driver

// File: source/pmod_cls_driver.sv
// top level of the serial LCD driver, wiring boot timer, loader, feeder and FSM
`timescale 1ns/1ps
`include "cls_config.svh"

module pmod_cls_driver
    import cls_pkg::*;
#(
    parameter int P_BOOT_TICKS = `CLS_BOOT_TICKS
) (
    input  logic          i_ext_spi_clk_x,
    input  logic          i_srst,
    input  logic          i_spi_ce_4x,
    // user command interface
    output logic          o_command_ready,
    input  cls_cmd_t      i_cmd,
    input  cls_line_t     i_text_line1,
    input  cls_line_t     i_text_line2,
    // transmit side of the external SPI master
    output cls_spi_req_t  o_spi_req,
    input  cls_spi_stat_t i_spi_stat
);

    // ------------------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------------------

    logic       boot_done;
    logic       load;
    logic       start;
    logic       feed_done;
    logic       has_text;
    cls_phase_t phase;
    cls_burst_t burst;

    cls_boot_timer #(
        .P_BOOT_TICKS (P_BOOT_TICKS)
    ) u_boot_timer (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .o_boot_done     (boot_done)
    );

    cls_driver_fsm u_driver_fsm (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .i_boot_done     (boot_done),
        .i_feed_done     (feed_done),
        .i_has_text      (has_text),
        .i_cmd           (i_cmd),
        .i_spi_stat      (i_spi_stat),
        .o_command_ready (o_command_ready),
        .o_load          (load),
        .o_start         (start),
        .o_phase         (phase)
    );

    cls_sequence_loader u_sequence_loader (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .i_load          (load),
        .i_cmd           (i_cmd),
        .i_text_line1    (i_text_line1),
        .i_text_line2    (i_text_line2),
        .i_phase         (phase),
        .o_burst         (burst),
        .o_has_text      (has_text)
    );

    cls_fifo_feeder u_fifo_feeder (
        .i_ext_spi_clk_x (i_ext_spi_clk_x),
        .i_srst          (i_srst),
        .i_spi_ce_4x     (i_spi_ce_4x),
        .i_start         (start),
        .i_burst         (burst),
        .i_spi_stat      (i_spi_stat),
        .o_spi_req       (o_spi_req),
        .o_done          (feed_done)
    );

endmodule : pmod_cls_driver

// File: source/cls_driver_fsm.sv
// command FSM for boot wait, command acceptance, the two bursts and the SPI idle waits
`timescale 1ns/1ps

module cls_driver_fsm
    import cls_pkg::*;
(
    input  logic          i_ext_spi_clk_x,
    input  logic          i_srst,
    input  logic          i_spi_ce_4x,
    input  logic          i_boot_done,
    input  logic          i_feed_done,
    input  logic          i_has_text,
    input  cls_cmd_t      i_cmd,
    input  cls_spi_stat_t i_spi_stat,
    output logic          o_command_ready,
    output logic          o_load,
    output logic          o_start,
    output cls_phase_t    o_phase
);

    cls_drv_state_t state;
    cls_drv_state_t state_nx;

    // state only advances on the clock-enable tick
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            state <= ST_BOOT;
        end else if (i_spi_ce_4x) begin
            state <= state_nx;
        end
    end

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------

    always_comb begin
        state_nx = state;
        case (state)
            ST_BOOT: begin
                if (i_boot_done) begin
                    state_nx = ST_IDLE;
                end
            end
            // any command bit is an acceptance, the loader sorts out priority
            ST_IDLE: begin
                if (|i_cmd) begin
                    state_nx = ST_LOAD;
                end
            end
            ST_LOAD: state_nx = ST_CMD_RUN;
            ST_CMD_RUN: begin
                if (i_feed_done) begin
                    state_nx = ST_CMD_WAIT;
                end
            end
            // a clear has no text, so it goes straight back to idle
            ST_CMD_WAIT: begin
                if (i_spi_stat.spi_idle) begin
                    state_nx = i_has_text ? ST_DAT_RUN : ST_IDLE;
                end
            end
            ST_DAT_RUN: begin
                if (i_feed_done) begin
                    state_nx = ST_DAT_WAIT;
                end
            end
            ST_DAT_WAIT: begin
                if (i_spi_stat.spi_idle) begin
                    state_nx = ST_IDLE;
                end
            end
            default: state_nx = ST_BOOT;
        endcase
    end

    // ------------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------------

    assign o_command_ready = (state == ST_IDLE);
    // load fires on the acceptance tick so command and text are sampled together
    assign o_load = (state == ST_IDLE) && (|i_cmd);
    // start is raised on the tick that enters a run state
    assign o_start = (state == ST_LOAD) ||
                     ((state == ST_CMD_WAIT) && i_spi_stat.spi_idle && i_has_text);

    // the text burst is selected from the command wait on, which is where the
    // feeder latches it for the second run
    always_comb begin
        case (state)
            ST_CMD_WAIT, ST_DAT_RUN, ST_DAT_WAIT: o_phase = PH_TEXT;
            default: o_phase = PH_CMD;
        endcase
    end

    a_boot_exit : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
        (state == ST_BOOT) ##1 (state != ST_BOOT) |-> $past(i_boot_done));

endmodule : cls_driver_fsm

// File: source/cls_fifo_feeder.sv
// byte streamer that loads one burst into the SPI transmit FIFO and starts the transfer
`timescale 1ns/1ps
`include "cls_config.svh"

module cls_fifo_feeder
    import cls_pkg::*;
(
    input  logic          i_ext_spi_clk_x,
    input  logic          i_srst,
    input  logic          i_spi_ce_4x,
    input  logic          i_start,
    input  cls_burst_t    i_burst,
    input  cls_spi_stat_t i_spi_stat,
    output cls_spi_req_t  o_spi_req,
    output logic          o_done
);

    localparam int lp_burst_w = `CLS_BURST_MAX_BYTES * `CLS_BYTE_W;

    logic [lp_burst_w-1:0] shift_bytes;
    cls_len_t              remain;
    cls_len_t              burst_len;
    logic                  active;
    logic                  accept;
    logic                  last;

    // ------------------------------------------------------------------------
    // handshake with the transmit FIFO
    // ------------------------------------------------------------------------

    // a byte moves only on a clock-enable tick with room in the FIFO
    assign accept = active && i_spi_ce_4x && i_spi_stat.tx_ready;
    assign last   = (remain == cls_len_t'(1));

    // control state, the byte count is also held for tx_len through the burst
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            active    <= 1'b0;
            remain    <= '0;
            burst_len <= '0;
        end else if (i_spi_ce_4x) begin
            if (i_start) begin
                active    <= (i_burst.len != '0);
                remain    <= i_burst.len;
                burst_len <= i_burst.len;
            end else if (accept) begin
                remain <= remain - 1'b1;
                if (last) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // the top byte is always the next one to send, under back-pressure
    // nothing shifts and the same byte waits for the next ready tick
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_spi_ce_4x && i_start) begin
            shift_bytes <= i_burst.bytes;
        end else if (accept) begin
            shift_bytes <= shift_bytes << `CLS_BYTE_W;
        end
    end

    // ------------------------------------------------------------------------
    // request outputs
    // ------------------------------------------------------------------------

    always_comb begin
        o_spi_req.tx_data    = active ? shift_bytes[lp_burst_w-1 -: `CLS_BYTE_W] : '0;
        o_spi_req.tx_enqueue = accept;
        o_spi_req.tx_len     = burst_len;
        // go travels with the final byte so the master sees the full burst queued
        o_spi_req.go_stand   = accept && last;
    end

    // the FSM moves on to its wait state on this same tick
    assign o_done = accept && last;

    a_enq_needs_ready : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
        o_spi_req.tx_enqueue |-> i_spi_stat.tx_ready);

    // the FSM must not restart the feeder while a burst is still streaming,
    // otherwise tx_len would change under the master
    a_no_restart : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
        active |-> !(i_start && i_spi_ce_4x));

endmodule : cls_fifo_feeder

// File: source/cls_sequence_loader.sv
// escape sequence and text burst registers for the accepted display command
`timescale 1ns/1ps
`include "cls_config.svh"

module cls_sequence_loader
    import cls_pkg::*;
(
    input  logic       i_ext_spi_clk_x,
    input  logic       i_srst,
    input  logic       i_spi_ce_4x,
    input  logic       i_load,
    input  cls_cmd_t   i_cmd,
    input  cls_line_t  i_text_line1,
    input  cls_line_t  i_text_line2,
    input  cls_phase_t i_phase,
    output cls_burst_t o_burst,
    output logic       o_has_text
);

    localparam int lp_clear_bytes = 4;
    // unused low bytes of each sequence are zero filled
    localparam int lp_clear_pad  = (`CLS_BURST_MAX_BYTES - lp_clear_bytes) * `CLS_BYTE_W;
    localparam int lp_cursor_pad = (`CLS_BURST_MAX_BYTES - `CLS_CMD_MAX_BYTES) * `CLS_BYTE_W;

    logic [`CLS_BURST_MAX_BYTES*`CLS_BYTE_W-1:0] cmd_bytes;
    cls_len_t                                     cmd_len;
    cls_line_t                                    text_bytes;
    cls_len_t                                     text_len;
    cls_byte_t                                    row_char;

    // row digit of the cursor sequence, '0' for line 1 and '1' for line 2
    assign row_char = i_cmd.line1 ? `CLS_ASCII_ZERO : (`CLS_ASCII_ZERO + cls_byte_t'(1));

    // byte counts decide how much is sent, a zero text count means no text burst
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            cmd_len  <= '0;
            text_len <= '0;
        end else if (i_spi_ce_4x && i_load) begin
            if (i_cmd.clear) begin
                cmd_len  <= cls_len_t'(lp_clear_bytes);
                text_len <= '0;
            end else begin
                cmd_len  <= cls_len_t'(`CLS_CMD_MAX_BYTES);
                text_len <= cls_len_t'(`CLS_LINE_BYTES);
            end
        end
    end

    // the load strobe comes on the acceptance tick, so the text is frozen here
    // and later changes on the text inputs cannot reach the display
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_spi_ce_4x && i_load) begin
            if (i_cmd.clear) begin
                cmd_bytes <= {`CLS_ASCII_ESC, `CLS_ASCII_BRACKET, `CLS_ASCII_ZERO,
                              `CLS_ASCII_CLEAR_CMD, {lp_clear_pad{1'b0}}};
            end else begin
                cmd_bytes <= {`CLS_ASCII_ESC, `CLS_ASCII_BRACKET, row_char,
                              `CLS_ASCII_SEMICOLON, `CLS_ASCII_ZERO, `CLS_ASCII_ZERO,
                              `CLS_ASCII_CURSOR_CMD, {lp_cursor_pad{1'b0}}};
            end
            // on a clear the text is captured too but its count stays zero
            text_bytes <= i_cmd.line1 ? i_text_line1 : i_text_line2;
        end
    end

    // the FSM phase picks which burst the feeder latches on its next start
    always_comb begin
        if (i_phase == PH_TEXT) begin
            o_burst.bytes = text_bytes;
            o_burst.len   = text_len;
        end else begin
            o_burst.bytes = cmd_bytes;
            o_burst.len   = cmd_len;
        end
    end

    assign o_has_text = (text_len != '0);

endmodule : cls_sequence_loader

// File: source/cls_boot_timer.sv
// boot wait counter that flags when the display controller is ready for commands
`timescale 1ns/1ps
`include "cls_config.svh"

module cls_boot_timer #(
    parameter int P_BOOT_TICKS = `CLS_BOOT_TICKS
) (
    input  logic i_ext_spi_clk_x,
    input  logic i_srst,
    input  logic i_spi_ce_4x,
    output logic o_boot_done
);

    // one spare count keeps the width valid for a single-tick wait
    localparam int lp_cnt_w = $clog2(P_BOOT_TICKS + 1);
    typedef logic [lp_cnt_w-1:0] boot_cnt_t;
    localparam boot_cnt_t lp_last = boot_cnt_t'(P_BOOT_TICKS - 1);

    boot_cnt_t tick_cnt;

    // the counter stops once the wait has passed, so the flag stays high
    // until the next reset
    always_ff @(posedge i_ext_spi_clk_x) begin
        if (i_srst) begin
            tick_cnt    <= '0;
            o_boot_done <= 1'b0;
        end else if (i_spi_ce_4x && !o_boot_done) begin
            if (tick_cnt == lp_last) begin
                o_boot_done <= 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    // the driver FSM relies on boot_done staying set once it has left ST_BOOT
    a_boot_done_sticky : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
        o_boot_done |=> o_boot_done);

endmodule : cls_boot_timer

// File: source/cls_pkg.sv
// byte, length and line types, burst and SPI port structs, and the driver enums
`include "cls_config.svh"

package cls_pkg;

    // ------------------------------------------------------------------------
    // plain vectors
    // ------------------------------------------------------------------------

    // one byte as it goes into the transmit FIFO
    typedef logic [`CLS_BYTE_W-1:0] cls_byte_t;
    // a byte count of one burst
    typedef logic [`CLS_LEN_W-1:0] cls_len_t;
    // a full text line, the leftmost character sits in the top byte
    typedef logic [`CLS_LINE_BYTES*`CLS_BYTE_W-1:0] cls_line_t;

    // ------------------------------------------------------------------------
    // grouped signals
    // ------------------------------------------------------------------------

    // bytes are left-aligned so the first byte sent is the most significant
    typedef struct packed {
        logic [`CLS_BURST_MAX_BYTES*`CLS_BYTE_W-1:0] bytes;
        cls_len_t                                     len;
    } cls_burst_t;

    // the three user commands, clear has the highest priority
    typedef struct packed {
        logic clear;
        logic line1;
        logic line2;
    } cls_cmd_t;

    // transmit side of the request going to the external SPI master
    typedef struct packed {
        cls_byte_t tx_data;
        logic      tx_enqueue;
        cls_len_t  tx_len;
        logic      go_stand;
    } cls_spi_req_t;

    // status coming back from the SPI master
    typedef struct packed {
        logic tx_ready;
        logic spi_idle;
    } cls_spi_stat_t;

    // which of the two loaded bursts is presented to the feeder
    typedef enum logic {PH_CMD, PH_TEXT} cls_phase_t;

    // command sequencing states of the driver
    typedef enum logic [2:0] {
        ST_BOOT, ST_IDLE, ST_LOAD, ST_CMD_RUN, ST_CMD_WAIT, ST_DAT_RUN, ST_DAT_WAIT
    } cls_drv_state_t;

endpackage : cls_pkg

// File: source/cls_config.svh
// widths, sequence lengths, ASCII codes and boot wait for the serial LCD driver
`ifndef CLS_CONFIG_SVH
`define CLS_CONFIG_SVH

// width of one byte on the SPI transmit FIFO
`define CLS_BYTE_W 8
// the cursor-position escape sequence is the longest command
`define CLS_CMD_MAX_BYTES 7
// text characters per display line
`define CLS_LINE_BYTES 16
// a burst holds at most one full text line
`define CLS_BURST_MAX_BYTES 16
// wide enough to count sixteen bytes
`define CLS_LEN_W 5
// 800 ms of clock-enable ticks at 2.5 MHz
`define CLS_BOOT_TICKS 2000000

// ASCII codes used in the display escape sequences
`define CLS_ASCII_ESC 8'h1B
`define CLS_ASCII_BRACKET 8'h5B
`define CLS_ASCII_ZERO 8'h30
`define CLS_ASCII_SEMICOLON 8'h3B
`define CLS_ASCII_CLEAR_CMD 8'h6A
`define CLS_ASCII_CURSOR_CMD 8'h48

`endif
